//--- Makefile
SIM := obj_dir/Vtb_tcdm_subsys

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

$(SIM): filelist.f $(shell cat filelist.f)
	verilator --binary --timing --assert -j 0 --top-module tb_tcdm_subsys -f filelist.f

clean:
	rm -rf obj_dir

//--- bench/tb_tcdm_subsys.sv
`timescale 1ns/1ps

module tb_tcdm_subsys;

  localparam int          NumPorts = 2;
  localparam int          NumBanks = 2;
  localparam logic [31:0] BaseAddr = 32'h1000_0000;
  localparam int          Timeout  = 200;

  logic                                         clk_i;
  logic                                         rst_ni;
  logic                                         enable_i;
  logic                                         stallable_i;
  logic [NumPorts-1:0]                          req_i;
  logic [NumPorts-1:0]                          wen_i;
  logic [NumPorts-1:0][tcdm_pkg::AddrWidth-1:0] add_i;
  logic [NumPorts-1:0][tcdm_pkg::BeWidth-1:0]   be_i;
  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0] data_i;
  logic [NumPorts-1:0]                          gnt_o;
  logic [NumPorts-1:0]                          r_valid_o;
  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0] r_data_o;

  logic [31:0]     exp_q [NumPorts];
  logic [8*24-1:0] name;
  logic [1:0]      mask;
  logic [1:0]      mode;  // 0 plain, 1 stall, 2 enable gated
  integer          seed;
  int              errors;
  int              tests;
  int              step_err;

  tcdm_subsys_top #(
    .NumPorts     (NumPorts),
    .NumBanks     (NumBanks),
    .WordsPerBank (64),
    .BaseAddr     (BaseAddr),
    .StallThresh  (10'd384)
  ) tcdm_subsys_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .enable_i    (enable_i),
    .stallable_i (stallable_i),
    .req_i       (req_i),
    .wen_i       (wen_i),
    .add_i       (add_i),
    .be_i        (be_i),
    .data_i      (data_i),
    .gnt_o       (gnt_o),
    .r_valid_o   (r_valid_o),
    .r_data_o    (r_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // word interleaving where the low word bits pick the bank
  function automatic int bank_of(input logic [31:0] addr);
    logic [31:0] word;
    word = (addr - BaseAddr) >> 2;
    return int'(word % NumBanks);
  endfunction

  task automatic tally_test(input logic [8*24-1:0] tname, input int n);
    tests++;
    errors += n;
    if (n == 0) begin
      $display("%0s: ok", tname);
    end else begin
      $display("%0s: %0d error(s)", tname, n);
    end
  endtask

  // entered 1 ns after an edge with the request already driven
  task automatic run_step();
    logic [NumPorts-1:0] pending;
    logic [NumPorts-1:0] resp_wait;
    logic [NumPorts-1:0] gnt;
    logic                same_bank;
    int                  cycles;
    pending   = mask;
    resp_wait = '0;
    cycles    = 0;
    same_bank = (mask == 2'b11) && (bank_of(add_i[0]) == bank_of(add_i[1]));
    if (mode == 2'd2) begin
      for (int c = 0; c < 20; c++) begin
        @(negedge clk_i);
        if (gnt_o !== '0 || r_valid_o !== '0) begin
          $display("Error %0s: gnt/r_valid with enable_i low expected 00/00, actual %b/%b",
                   name, gnt_o, r_valid_o);
          step_err++;
        end
      end
      @(posedge clk_i);
      #1;
      enable_i = 1'b1;
    end
    while ((pending != '0 || resp_wait != '0) && cycles < Timeout) begin
      @(negedge clk_i);
      gnt = gnt_o;
      if (r_valid_o !== resp_wait) begin
        $display("Error %0s: r_valid expected %b, actual %b", name, resp_wait, r_valid_o);
        step_err++;
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (resp_wait[p] && r_data_o[p] !== exp_q[p]) begin
          $display("Error %0s: port %0d r_data expected %h, actual %h",
                   name, p, exp_q[p], r_data_o[p]);
          step_err++;
        end
      end
      if ((gnt & ~pending) != '0) begin
        $display("Error %0s: grant given to a port without a request", name);
        step_err++;
      end
      // no stall outside mode 1, so the shared bank must grant one port
      if (same_bank && pending == 2'b11 &&
          (gnt == 2'b11 || (mode != 2'd1 && gnt == 2'b00))) begin
        $display("Error %0s: shared bank grants expected 01 or 10, actual %b", name, gnt);
        step_err++;
      end
      if (mode == 2'd0 && mask == 2'b11 && !same_bank && cycles == 0 && gnt != 2'b11) begin
        $display("Error %0s: first cycle grants expected 11, actual %b", name, gnt);
        step_err++;
      end
      resp_wait = gnt & pending;
      pending   = pending & ~gnt;
      @(posedge clk_i);
      #1;
      req_i = pending;  // granted ports drop req
      if (mode == 2'd1) begin
        stallable_i = ($random(seed) % 4) != 0;
      end
      cycles++;
    end
    if (pending != '0 || resp_wait != '0) begin
      $display("Error %0s: request still open after %0d cycles", name, Timeout);
      step_err++;
      req_i = '0;
    end
    stallable_i = 1'b0;
  endtask

  initial begin
    integer           fd;
    integer           cnt;
    logic [8*200-1:0] line;
    logic             w0;
    logic             w1;
    logic [31:0]      a0;
    logic [31:0]      a1;
    logic [3:0]       b0;
    logic [3:0]       b1;
    logic [31:0]      d0;
    logic [31:0]      d1;
    logic [31:0]      e0;
    logic [31:0]      e1;
    seed        = 32'h21d7;
    errors      = 0;
    tests       = 0;
    step_err    = 0;
    rst_ni      = 1'b0;
    enable_i    = 1'b0;
    stallable_i = 1'b0;
    req_i       = '0;
    wen_i       = '1;
    add_i       = '0;
    be_i        = '0;
    data_i      = '0;

    for (int c = 0; c < 16; c++) begin
      @(negedge clk_i);
      if (gnt_o !== '0 || r_valid_o !== '0) begin
        $display("Error reset: gnt/r_valid expected 00/00, actual %b/%b", gnt_o, r_valid_o);
        step_err++;
      end
    end
    @(posedge clk_i);
    #1;
    rst_ni   = 1'b1;
    enable_i = 1'b1;
    @(negedge clk_i);
    if (gnt_o !== '0 || r_valid_o !== '0) begin
      $display("Error reset: gnt/r_valid after release expected 00/00, actual %b/%b",
               gnt_o, r_valid_o);
      step_err++;
    end
    tests++;
    errors += step_err;
    $display("reset: %0d error(s)", step_err);
    @(posedge clk_i);
    #1;

    fd = $fopen("bench/tcdm_vectors.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open bench/tcdm_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        cnt  = $fgets(line, fd);
        if (cnt > 0) begin
          cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", name, mask, mode,
                        w0, a0, b0, d0, e0, w1, a1, b1, d1, e1);
          if (cnt == 13) begin
            wen_i    = {w1, w0};
            add_i[0] = a0;
            add_i[1] = a1;
            be_i[0]  = b0;
            be_i[1]  = b1;
            data_i[0] = d0;
            data_i[1] = d1;
            exp_q[0] = e0;
            exp_q[1] = e1;
            enable_i = (mode != 2'd2);
            stallable_i = (mode == 2'd1) ? (($random(seed) % 4) != 0) : 1'b0;
            req_i    = mask;
            step_err = 0;
            run_step();
            tally_test(name, step_err);
          end else if (cnt > 1) begin
            $display("Error: malformed line in the vector file");
            errors++;
          end
        end
      end
      $fclose(fd);
    end

    errors += tcdm_subsys_top_inst.tcdm_subsys_chk_inst.fail_cnt;
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- bench/tcdm_subsys_chk.sv
`timescale 1ns/1ps

module tcdm_subsys_chk #(
  parameter int NumPorts = 2
) (
  input logic                                          clk_i,
  input logic                                          rst_ni,
  input logic [NumPorts-1:0]                           req_i,
  input logic [NumPorts-1:0]                           wen_i,
  input logic [NumPorts-1:0][tcdm_pkg::AddrWidth-1:0]  add_i,
  input logic [NumPorts-1:0][tcdm_pkg::BeWidth-1:0]    be_i,
  input logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0]  data_i,
  input logic [NumPorts-1:0]                           gnt_o,
  input logic [NumPorts-1:0]                           r_valid_o
);

  int fail_cnt = 0;  // summed into the testbench result

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_o[p] |-> req_i[p])
    else begin
      fail_cnt++;
      $error("port %0d granted without a request", p);
    end

    // one cycle response latency
    rsp_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (req_i[p] && gnt_o[p]) |=> r_valid_o[p])
    else begin
      fail_cnt++;
      $error("port %0d missing r_valid after grant", p);
    end

    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (req_i[p] && !gnt_o[p]) |=> (req_i[p] && $stable(add_i[p]) && $stable(wen_i[p]) &&
                                   $stable(be_i[p]) && $stable(data_i[p])))
    else begin
      fail_cnt++;
      $error("port %0d request changed before grant", p);
    end
  end

endmodule

bind tcdm_subsys_top tcdm_subsys_chk #(
  .NumPorts (NumPorts)
) tcdm_subsys_chk_inst (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (req_i),
  .wen_i     (wen_i),
  .add_i     (add_i),
  .be_i      (be_i),
  .data_i    (data_i),
  .gnt_o     (gnt_o),
  .r_valid_o (r_valid_o)
);

//--- bench/tcdm_vectors.txt
# test mask mode, then for port 0 and port 1: wen(1=read) addr be data expected_rdata
# mode 0 plain, 1 random stallable_i, 2 enable_i held low for 20 cycles first
wr_full        1 0  0 10000000 f deadbeef deadbeef  1 00000000 0 00000000 00000000
rd_full        1 0  1 10000000 0 00000000 deadbeef  1 00000000 0 00000000 00000000
wr_full_p1     2 0  1 00000000 0 00000000 00000000  0 10000004 f 12345678 12345678
rd_full_p1     2 0  1 00000000 0 00000000 00000000  1 10000004 0 00000000 12345678
wr_part        1 0  0 10000000 5 a1b2c3d4 deb2bed4  1 00000000 0 00000000 00000000
rd_part        1 0  1 10000000 0 00000000 deb2bed4  1 00000000 0 00000000 00000000
wr_part_hi     2 0  1 00000000 0 00000000 00000000  0 10000004 a ffeeddcc ff34dd78
diff_bank_wr   3 0  0 10000008 f 11112222 11112222  0 1000000c f 33334444 33334444
conflict_wr    3 0  0 10000010 f 55556666 55556666  0 10000018 f 77778888 77778888
conflict_rd    3 0  1 10000018 0 00000000 77778888  1 10000010 0 00000000 55556666
conflict_word  3 0  1 10000000 0 00000000 deb2bed4  1 10000000 0 00000000 deb2bed4
diff_bank_rd   3 0  1 1000000c 0 00000000 33334444  1 10000008 0 00000000 11112222
stall_wr       3 1  0 10000020 f cafef00d cafef00d  0 10000024 f 0badc0de 0badc0de
stall_rd       3 1  1 10000024 0 00000000 0badc0de  1 10000020 0 00000000 cafef00d
stall_part     1 1  0 10000020 c 12340000 1234f00d  1 00000000 0 00000000 00000000
stall_conflict 3 1  1 10000020 0 00000000 1234f00d  1 10000010 0 00000000 55556666
stall_rd_p1    2 1  1 00000000 0 00000000 00000000  1 10000004 0 00000000 ff34dd78
en_gate_wr     3 2  0 10000030 f aabbccdd aabbccdd  1 10000008 0 00000000 11112222
en_gate_rd     1 2  1 10000030 0 00000000 aabbccdd  1 00000000 0 00000000 00000000

//--- filelist.f
src/tcdm_pkg.sv
src/tcdm_if.sv
src/tcdm_stall_gen.sv
src/tcdm_bank.sv
src/tcdm_xbar.sv
src/tcdm_subsys_top.sv
bench/tcdm_subsys_chk.sv
bench/tb_tcdm_subsys.sv

//--- src/tcdm_bank.sv
`timescale 1ns/1ps

module tcdm_bank #(
  parameter int WordsPerBank = 64
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  tcdm_if.slave mem
);

  localparam int RowW = (WordsPerBank > 1) ? $clog2(WordsPerBank) : 1;

  tcdm_pkg::tcdm_word_t mem_q [WordsPerBank];
  tcdm_pkg::tcdm_word_t rdata;
  tcdm_pkg::tcdm_word_t din;
  tcdm_pkg::tcdm_word_t wdata;
  logic [RowW-1:0]      row;
  logic [tcdm_pkg::DataWidth-1:0] r_data_q;
  logic                 r_valid_q;

  assign row      = mem.add[RowW-1:0];  // xbar already stripped the bank bits
  assign din.word = mem.data;
  assign rdata    = mem_q[row];

  always_comb begin
    wdata = rdata;
    for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
      if (mem.be[b]) begin
        wdata.bytes[b] = din.bytes[b];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem.req && !mem.wen) begin
      mem_q[row] <= wdata;
    end
    if (mem.req) begin
      r_data_q <= mem.wen ? rdata.word : wdata.word;  // writes echo the merged word
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= mem.req;
    end
  end

  assign mem.gnt     = 1'b1;  // arbitration is upstream
  assign mem.r_data  = r_data_q;
  assign mem.r_valid = r_valid_q;

endmodule

//--- src/tcdm_if.sv
`timescale 1ns/1ps

interface tcdm_if;

  logic                            req;
  logic                            gnt;
  logic [tcdm_pkg::AddrWidth-1:0]  add;
  logic                            wen;     // 1 = read
  logic [tcdm_pkg::BeWidth-1:0]    be;
  logic [tcdm_pkg::DataWidth-1:0]  data;
  logic [tcdm_pkg::DataWidth-1:0]  r_data;
  logic                            r_valid;

  modport master (
    output req, add, wen, be, data,
    input  gnt, r_data, r_valid
  );

  modport slave (
    input  req, add, wen, be, data,
    output gnt, r_data, r_valid
  );

endinterface

//--- src/tcdm_pkg.sv
package tcdm_pkg;

  // byte address and data word sizes
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int BeWidth   = DataWidth / 8;

  // the bank reads the word whole and merges it per byte
  typedef union packed {
    logic [DataWidth-1:0]    word;
    logic [BeWidth-1:0][7:0] bytes;
  } tcdm_word_t;

  // stall generator state with taps 16/14/13/11
  typedef logic [15:0] lfsr_t;

endpackage

//--- src/tcdm_stall_gen.sv
`timescale 1ns/1ps

module tcdm_stall_gen #(
  parameter int         NumPorts    = 2,
  parameter logic [9:0] StallThresh = 10'd0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                stallable_i,
  output logic [NumPorts-1:0] stall_o
);

  for (genvar i = 0; i < NumPorts; i++) begin : gen_port
    // odd multiplier keeps the seeds nonzero and distinct
    localparam tcdm_pkg::lfsr_t Seed = tcdm_pkg::lfsr_t'((i + 1) * 16'h9e37);

    tcdm_pkg::lfsr_t lfsr_q;
    logic            fb;

    assign fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        lfsr_q <= Seed;
      end else begin
        lfsr_q <= {lfsr_q[14:0], fb};  // steps every cycle
      end
    end

    // probability StallThresh/1024
    assign stall_o[i] = stallable_i && (lfsr_q[9:0] < StallThresh);
  end

endmodule

//--- src/tcdm_subsys_top.sv
`timescale 1ns/1ps

module tcdm_subsys_top #(
  parameter int                             NumPorts     = 2,
  parameter int                             NumBanks     = 2,
  parameter int                             WordsPerBank = 64,
  parameter logic [tcdm_pkg::AddrWidth-1:0] BaseAddr     = '0,
  parameter logic [9:0]                     StallThresh  = 10'd0
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          enable_i,
  input  logic                                          stallable_i,
  input  logic [NumPorts-1:0]                           req_i,
  input  logic [NumPorts-1:0]                           wen_i,
  input  logic [NumPorts-1:0][tcdm_pkg::AddrWidth-1:0]  add_i,
  input  logic [NumPorts-1:0][tcdm_pkg::BeWidth-1:0]    be_i,
  input  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0]  data_i,
  output logic [NumPorts-1:0]                           gnt_o,
  output logic [NumPorts-1:0]                           r_valid_o,
  output logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0]  r_data_o
);

  logic [NumPorts-1:0] stall;

  tcdm_if mst_if [NumPorts] ();
  tcdm_if bnk_if [NumBanks] ();

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    assign mst_if[p].req  = req_i[p];
    assign mst_if[p].wen  = wen_i[p];
    assign mst_if[p].add  = add_i[p];
    assign mst_if[p].be   = be_i[p];
    assign mst_if[p].data = data_i[p];

    assign gnt_o[p]     = mst_if[p].gnt;
    assign r_valid_o[p] = mst_if[p].r_valid;
    assign r_data_o[p]  = mst_if[p].r_data;
  end

  tcdm_stall_gen #(
    .NumPorts    (NumPorts),
    .StallThresh (StallThresh)
  ) tcdm_stall_gen_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stallable_i (stallable_i),
    .stall_o     (stall)
  );

  tcdm_xbar #(
    .NumPorts     (NumPorts),
    .NumBanks     (NumBanks),
    .WordsPerBank (WordsPerBank),
    .BaseAddr     (BaseAddr)
  ) tcdm_xbar_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable_i (enable_i),
    .stall_i  (stall),
    .mst      (mst_if),
    .bnk      (bnk_if)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    tcdm_bank #(
      .WordsPerBank (WordsPerBank)
    ) tcdm_bank_inst (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .mem    (bnk_if[b])
    );
  end

endmodule

//--- src/tcdm_xbar.sv
`timescale 1ns/1ps

module tcdm_xbar #(
  parameter int                             NumPorts     = 2,
  parameter int                             NumBanks     = 2,
  parameter int                             WordsPerBank = 64,
  parameter logic [tcdm_pkg::AddrWidth-1:0] BaseAddr     = '0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  logic [NumPorts-1:0] stall_i,
  tcdm_if.slave               mst [NumPorts],
  tcdm_if.master              bnk [NumBanks]
);

  localparam int AW       = tcdm_pkg::AddrWidth;
  localparam int DW       = tcdm_pkg::DataWidth;
  localparam int BW       = tcdm_pkg::BeWidth;
  localparam int PortIdxW = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  localparam int BankIdxW = (NumBanks > 1) ? $clog2(NumBanks) : 1;
  localparam int RowW     = (WordsPerBank > 1) ? $clog2(WordsPerBank) : 1;

  // flattened port side
  logic [NumPorts-1:0]         p_req;
  logic [NumPorts-1:0]         p_wen;
  logic [NumPorts-1:0]         p_gnt;
  logic [NumPorts-1:0]         p_rvalid;
  logic [AW-1:0]               p_word [NumPorts];
  logic [BankIdxW-1:0]         p_bank [NumPorts];
  logic [RowW-1:0]             p_row  [NumPorts];
  logic [BW-1:0]               p_be   [NumPorts];
  logic [DW-1:0]               p_data [NumPorts];
  logic [DW-1:0]               p_rdata [NumPorts];

  // flattened bank side
  logic [NumBanks-1:0]         b_gnt;
  logic [NumBanks-1:0]         b_rvalid;
  logic [DW-1:0]               b_rdata [NumBanks];

  logic [NumBanks-1:0]         win_vld;
  logic [PortIdxW-1:0]         win_idx [NumBanks];
  logic [PortIdxW-1:0]         ptr_q   [NumBanks];
  logic [PortIdxW-1:0]         owner_q [NumBanks];

  for (genvar p = 0; p < NumPorts; p++) begin : gen_mst
    assign p_req[p]  = mst[p].req;
    assign p_wen[p]  = mst[p].wen;
    assign p_be[p]   = mst[p].be;
    assign p_data[p] = mst[p].data;
    assign p_word[p] = (mst[p].add - BaseAddr) >> $clog2(BW);
    assign p_bank[p] = BankIdxW'(p_word[p] % NumBanks);  // low word bits pick the bank
    assign p_row[p]  = RowW'(p_word[p] / NumBanks);

    assign mst[p].gnt     = p_gnt[p];
    assign mst[p].r_valid = p_rvalid[p];
    assign mst[p].r_data  = p_rdata[p];
  end

  // round robin from ptr_q where the lowest offset wins
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      win_vld[b] = 1'b0;
      win_idx[b] = '0;
      for (int k = NumPorts - 1; k >= 0; k--) begin
        automatic int p = int'(ptr_q[b]) + k;
        if (p >= NumPorts) begin
          p = p - NumPorts;
        end
        if (enable_i && p_req[p] && !stall_i[p] && (p_bank[p] == BankIdxW'(b))) begin
          win_vld[b] = 1'b1;
          win_idx[b] = PortIdxW'(p);
        end
      end
    end
  end

  always_comb begin
    p_gnt    = '0;
    p_rvalid = '0;
    for (int p = 0; p < NumPorts; p++) begin
      p_rdata[p] = '0;
      for (int b = 0; b < NumBanks; b++) begin
        if (win_vld[b] && b_gnt[b] && (win_idx[b] == PortIdxW'(p))) begin
          p_gnt[p] = 1'b1;
        end
        if (b_rvalid[b] && (owner_q[b] == PortIdxW'(p))) begin
          p_rvalid[p] = 1'b1;
          p_rdata[p]  = b_rdata[b];
        end
      end
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bnk
    assign bnk[b].req  = win_vld[b];
    assign bnk[b].add  = AW'(p_row[win_idx[b]]);
    assign bnk[b].wen  = p_wen[win_idx[b]];
    assign bnk[b].be   = p_be[win_idx[b]];
    assign bnk[b].data = p_data[win_idx[b]];

    assign b_gnt[b]    = bnk[b].gnt;
    assign b_rvalid[b] = bnk[b].r_valid;
    assign b_rdata[b]  = bnk[b].r_data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        ptr_q[b]   <= '0;
        owner_q[b] <= '0;
      end else if (win_vld[b] && b_gnt[b]) begin
        ptr_q[b]   <= PortIdxW'((int'(win_idx[b]) + 1) % NumPorts);  // move past winner
        owner_q[b] <= win_idx[b];  // response goes back here
      end
    end
  end

endmodule
